//--- common/tdc_pkg.sv
// Measurement constants and output word layout for the TDC channel.
// Imported by every RTL module of the channel; widths here set the datapath.

package tdc_pkg;

    // sampling
    localparam int SAMPLE_W = 16;   // samples per CLK40 word with bit 0 newest
    localparam int ONES_W   = 5;    // popcount of one sample word up to 16

    // measured value
    localparam int TDC_W    = 12;   // width of the time-over-threshold value
    localparam int ACC_W    = TDC_W + 1;  // top bit flags overflow

    // output word fields from msb down are identifier, event number and value
    localparam int ID_W     = 4;
    localparam int EVENT_W  = 16;
    localparam int WORD_W   = ID_W + EVENT_W + TDC_W;   // 32 bit word

    // saturating lost-word counter
    localparam int LOST_W   = 8;

endpackage

//--- common/bus_pkg.sv
// Register map of the byte-wide bus of the TDC channel.
// Addresses and config bit positions shared by the top level and the register bank.

package bus_pkg;

    localparam int BUS_ADDR_W = 16;
    localparam int BUS_DATA_W = 8;

    // register addresses
    localparam logic [BUS_ADDR_W-1:0] ADDR_CTRL   = 16'd0;  // write is soft reset, read gives scratch 0
    localparam logic [BUS_ADDR_W-1:0] ADDR_CONF   = 16'd1;  // configuration
    localparam logic [BUS_ADDR_W-1:0] ADDR_LOST   = 16'd2;  // lost-word counter
    localparam logic [BUS_ADDR_W-1:0] ADDR_EVT_LO = 16'd3;  // live low byte of the event counter
    localparam logic [BUS_ADDR_W-1:0] ADDR_EVT_HI = 16'd4;  // snapshot of the event counter high byte

    // bits of the configuration register
    localparam int CONF_EN_BIT  = 0;    // measurement enable
    localparam int CONF_ARM_BIT = 1;    // wait for an arm edge before measuring

endpackage

//--- verilog/word_fifo.sv
// Synchronous show-ahead FIFO for the finished TDC words.
// rdata shows the oldest word while empty is low; rd pops it.
// Writes while full and reads while empty are ignored.

`timescale 1ns/1ps

module word_fifo #(
    parameter int width = tdc_pkg::WORD_W,
    parameter int depth = 512       // power of two
) (
    input  logic             CLK40,
    input  logic             clear,
    input  logic             wr,
    input  logic [width-1:0] wdata,
    input  logic             rd,
    output logic [width-1:0] rdata,
    output logic             full,
    output logic             empty
);
    localparam int PTR_W = $clog2(depth);

    logic [width-1:0] mem [depth];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;        // occupancy, 0..depth
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == (PTR_W + 1)'(depth));
    assign empty = (count == '0);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge CLK40) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr];     // show-ahead

    always_ff @(posedge CLK40) begin
        if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- tdc/tdc_reg_bank.sv
// Bus register bank of the TDC channel.
// Decodes bus writes and reads, holds scratch and configuration registers,
// makes the channel clear and keeps the high-byte snapshot of the event counter.

`timescale 1ns/1ps

module tdc_reg_bank (
    input  logic                            CLK40,
    input  logic                            RST,
    input  logic [bus_pkg::BUS_ADDR_W-1:0]  bus_add,
    input  logic [bus_pkg::BUS_DATA_W-1:0]  bus_data_in,
    input  logic                            bus_wr,
    input  logic                            bus_rd,
    output logic [bus_pkg::BUS_DATA_W-1:0]  bus_data_out,   // valid the cycle after bus_rd
    output logic                            clear,
    output logic                            conf_en,
    output logic                            conf_arm,
    input  logic [tdc_pkg::EVENT_W-1:0]     event_cnt,
    input  logic [tdc_pkg::LOST_W-1:0]      lost_cnt
);
    import tdc_pkg::*;
    import bus_pkg::*;

    logic [BUS_DATA_W-1:0] scratch_q;   // scratch register 0
    logic [BUS_DATA_W-1:0] conf_q;
    logic [BUS_DATA_W-1:0] evt_hi_q;    // high byte captured on low-byte read
    logic                  soft_rst_q;
    logic                  ctrl_wr;

    assign ctrl_wr = bus_wr && (bus_add == ADDR_CTRL);

    // soft reset lasts one cycle after the write to the control address
    always_ff @(posedge CLK40) begin
        if (RST) begin
            soft_rst_q <= 1'b0;
        end else begin
            soft_rst_q <= ctrl_wr;
        end
    end

    assign clear = RST | soft_rst_q;

    // scratch keeps the last control write, so writing 0 also clears it
    always_ff @(posedge CLK40) begin
        if (RST) begin
            scratch_q <= '0;
        end else if (ctrl_wr) begin
            scratch_q <= bus_data_in;
        end
    end

    always_ff @(posedge CLK40) begin
        if (clear) begin
            conf_q <= '0;
        end else if (bus_wr && (bus_add == ADDR_CONF)) begin
            conf_q <= bus_data_in;
        end
    end

    assign conf_en  = conf_q[CONF_EN_BIT];
    assign conf_arm = conf_q[CONF_ARM_BIT];

    // registered read path
    always_ff @(posedge CLK40) begin
        if (RST) begin
            bus_data_out <= '0;
            evt_hi_q     <= '0;
        end else if (bus_rd) begin
            case (bus_add)
                ADDR_CTRL: bus_data_out <= scratch_q;
                ADDR_CONF: bus_data_out <= conf_q;
                ADDR_LOST: bus_data_out <= lost_cnt;
                ADDR_EVT_LO: begin
                    bus_data_out <= event_cnt[BUS_DATA_W-1:0];
                    evt_hi_q     <= event_cnt[EVENT_W-1 -: BUS_DATA_W];  // freeze upper half
                end
                ADDR_EVT_HI: bus_data_out <= evt_hi_q;
                default: bus_data_out <= '0;    // unmapped reads as 0
            endcase
        end
    end

endmodule

//--- tdc/tdc_measure.sv
// Pulse-width measurement of the TDC channel.
// Counts high samples of a pulse over successive 16-sample words and builds
// the output word {identifier, event number, value}, written to the FIFO on finish.

`timescale 1ns/1ps

module tdc_measure #(
    parameter logic [tdc_pkg::ID_W-1:0] data_identifier = 4'b0100
) (
    input  logic                            CLK40,
    input  logic                            clear,
    input  logic [tdc_pkg::SAMPLE_W-1:0]    sample_in,
    input  logic                            arm_tdc,
    input  logic                            conf_en,
    input  logic                            conf_arm,
    input  logic                            fifo_full,
    output logic                            hit,
    output logic                            fifo_wr,
    output logic [tdc_pkg::WORD_W-1:0]      fifo_wdata,
    output logic [tdc_pkg::EVENT_W-1:0]     event_cnt,
    output logic [tdc_pkg::LOST_W-1:0]      lost_cnt
);
    import tdc_pkg::*;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ARMED = 2'd1,
        COUNT = 2'd2
    } state_t;

    state_t              state_q;
    state_t              state_d;
    logic [SAMPLE_W-1:0] data_q;        // sample word under decode
    logic [ONES_W-1:0]   ones;
    logic                zero_seen;
    logic                short_pulse;
    logic                start_word;
    logic                arm_meta;
    logic                arm_sync;
    logic                arm_prev;
    logic                arm_edge;
    logic                finish;
    logic                start;
    logic [ACC_W-1:0]    acc_q;
    logic [ACC_W-1:0]    sum;
    logic                acc_ovf;
    logic [TDC_W-1:0]    tdc_val;

    always_ff @(posedge CLK40) begin
        data_q <= sample_in;
    end

    assign hit = |data_q;

    always_comb begin
        ones = '0;
        for (int i = 0; i < SAMPLE_W; i++) begin
            ones = ones + ONES_W'(data_q[i]);
        end
    end

    assign zero_seen   = ~&data_q;
    assign short_pulse = (ones != '0) && !data_q[0];    // pulse ended inside this word
    assign start_word  = (ones != '0) && data_q[0];     // pulse still high at newest sample

    // two-flop synchronizer and rising-edge detect for the arm input
    always_ff @(posedge CLK40) begin
        if (clear) begin
            arm_meta <= 1'b0;
            arm_sync <= 1'b0;
            arm_prev <= 1'b0;
        end else begin
            arm_meta <= arm_tdc;
            arm_sync <= arm_meta;
            arm_prev <= arm_sync;
        end
    end

    assign arm_edge = arm_sync && !arm_prev;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (conf_en && !conf_arm && start_word) begin
                    state_d = COUNT;
                end else if (conf_en && conf_arm && arm_edge) begin
                    state_d = ARMED;
                end
            end
            ARMED: begin
                if (start_word) begin
                    state_d = COUNT;
                end else if (!conf_en) begin
                    state_d = IDLE;
                end
            end
            COUNT: begin
                if (zero_seen || !conf_en) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge CLK40) begin
        if (clear) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign finish = ((state_q == COUNT) && (state_d == IDLE))
                  || ((state_q != COUNT) && conf_en && short_pulse);
    assign start  = (state_q != COUNT) && (state_d == COUNT);

    // zero in the accumulator marks an overflowed pulse until the next start
    assign sum     = acc_q + ACC_W'(ones);
    assign acc_ovf = (acc_q == '0) || sum[ACC_W-1];

    always_ff @(posedge CLK40) begin
        if (start) begin
            acc_q <= ACC_W'(ones);
        end else if (state_q == COUNT) begin
            acc_q <= acc_ovf ? '0 : sum;
        end
    end

    always_comb begin
        if (state_q != COUNT) begin
            tdc_val = TDC_W'(ones);     // short pulse
        end else if (acc_ovf) begin
            tdc_val = '0;               // overflow bin
        end else begin
            tdc_val = sum[TDC_W-1:0];
        end
    end

    assign fifo_wr    = finish && !fifo_full;
    assign fifo_wdata = {data_identifier, event_cnt, tdc_val};

    always_ff @(posedge CLK40) begin
        if (clear) begin
            event_cnt <= '0;
            lost_cnt  <= '0;
        end else if (finish) begin
            event_cnt <= event_cnt + 1'b1;  // counts dropped words too
            if (fifo_full && (lost_cnt != '1)) begin
                lost_cnt <= lost_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/tdc_core.sv
// Top level of the TDC channel that connects register bank, measurement block and output FIFO.
// Feed one 16-sample word per CLK40 cycle; pop finished words from the FIFO side.

`timescale 1ns/1ps

module tdc_core #(
    parameter logic [tdc_pkg::ID_W-1:0] data_identifier = 4'b0100,
    parameter int                       fifo_depth      = 512
) (
    input  logic                            CLK40,
    input  logic                            RST,

    input  logic [tdc_pkg::SAMPLE_W-1:0]    sample_in,  // deserialized samples
    input  logic                            arm_tdc,    // asynchronous arm input
    output logic                            hit,

    input  logic [bus_pkg::BUS_ADDR_W-1:0]  bus_add,
    input  logic [bus_pkg::BUS_DATA_W-1:0]  bus_data_in,
    input  logic                            bus_wr,
    input  logic                            bus_rd,
    output logic [bus_pkg::BUS_DATA_W-1:0]  bus_data_out,

    input  logic                            fifo_read,
    output logic                            fifo_empty,
    output logic [tdc_pkg::WORD_W-1:0]      fifo_data
);
    import tdc_pkg::*;

    logic               clear;      // channel reset, hard or soft
    logic               conf_en;
    logic               conf_arm;
    logic [EVENT_W-1:0] event_cnt;
    logic [LOST_W-1:0]  lost_cnt;
    logic               fifo_wr;
    logic [WORD_W-1:0]  fifo_wdata;
    logic               fifo_full;

    tdc_reg_bank u_reg_bank (
        .CLK40        (CLK40),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .clear        (clear),
        .conf_en      (conf_en),
        .conf_arm     (conf_arm),
        .event_cnt    (event_cnt),
        .lost_cnt     (lost_cnt)
    );

    tdc_measure #(
        .data_identifier (data_identifier)
    ) u_measure (
        .CLK40      (CLK40),
        .clear      (clear),
        .sample_in  (sample_in),
        .arm_tdc    (arm_tdc),
        .conf_en    (conf_en),
        .conf_arm   (conf_arm),
        .fifo_full  (fifo_full),
        .hit        (hit),
        .fifo_wr    (fifo_wr),
        .fifo_wdata (fifo_wdata),
        .event_cnt  (event_cnt),
        .lost_cnt   (lost_cnt)
    );

    word_fifo #(
        .width (WORD_W),
        .depth (fifo_depth)
    ) u_fifo (
        .CLK40 (CLK40),
        .clear (clear),
        .wr    (fifo_wr),
        .wdata (fifo_wdata),
        .rd    (fifo_read),
        .rdata (fifo_data),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

endmodule

//--- bench/clock_gen.sv
// Clock and reset source for the TDC channel testbench.
// 10 ns CLK40; RST held high for the first 3 rising edges.

`timescale 1ns/1ps

module clock_gen (
    output logic CLK40,
    output logic RST
);
    initial begin
        CLK40 = 1'b0;
        forever #5 CLK40 = ~CLK40;
    end

    initial begin
        RST = 1'b1;
        repeat (3) @(posedge CLK40);
        RST <= 1'b0;    // released on the third edge
    end

endmodule

//--- bench/tb_tdc_core.sv
// Testbench of the TDC channel that drives sample words, arm and bus, runs a
// reference model of the measurement rules and checks every FIFO word.
// Popped words are compared with the model queue by a separate process.

`timescale 1ns/1ps

module tb_tdc_core;
    import tdc_pkg::*;
    import bus_pkg::*;

    localparam logic [ID_W-1:0] DATA_ID    = 4'hA;
    localparam int              FIFO_DEPTH = 64;

    typedef enum int {M_IDLE, M_ARMED, M_COUNT} mstate_t;

    logic                  CLK40;
    logic                  RST;
    logic [SAMPLE_W-1:0]   sample_in;
    logic                  arm_tdc;
    logic                  hit;
    logic [BUS_ADDR_W-1:0] bus_add;
    logic [BUS_DATA_W-1:0] bus_data_in;
    logic                  bus_wr;
    logic                  bus_rd;
    logic [BUS_DATA_W-1:0] bus_data_out;
    logic                  fifo_read = 1'b0;
    logic                  fifo_empty;
    logic [WORD_W-1:0]     fifo_data;

    logic                  drain_en = 1'b1;  // compare process keeps popping
    logic                  hit_check_en = 1'b0;
    logic                  hit_ref;
    logic [WORD_W-1:0]     exp_q[$];         // words expected in the FIFO
    mstate_t               m_state;
    int                    m_acc;
    logic                  m_en;
    logic                  m_arm;
    logic [EVENT_W-1:0]    m_evt;
    int                    m_lost;
    int                    errors = 0;
    int                    checks = 0;
    int                    tests = 0;
    int                    popped = 0;

    clock_gen u_clk (.CLK40(CLK40), .RST(RST));

    tdc_core #(
        .data_identifier (DATA_ID),
        .fifo_depth      (FIFO_DEPTH)
    ) uut (
        .CLK40        (CLK40),
        .RST          (RST),
        .sample_in    (sample_in),
        .arm_tdc      (arm_tdc),
        .hit          (hit),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .fifo_read    (fifo_read),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic int count_ones(input logic [SAMPLE_W-1:0] w);
        int n;
        n = 0;
        for (int i = 0; i < SAMPLE_W; i++) begin
            if (w[i]) n++;
        end
        return n;
    endfunction

    function automatic void model_reset();
        m_state = M_IDLE;
        m_acc   = 0;
        m_en    = 1'b0;
        m_arm   = 1'b0;
        m_evt   = '0;
        m_lost  = 0;
        exp_q.delete();
    endfunction

    // expected word on a finish; dropped and counted when the FIFO is full
    function automatic void model_finish(input int value);
        if (exp_q.size() >= FIFO_DEPTH) begin
            if (m_lost < 255) m_lost++;
        end else begin
            exp_q.push_back({DATA_ID, m_evt, TDC_W'(value)});
        end
        m_evt = m_evt + 16'd1;
    endfunction

    // running sum that drops to 0 once the pulse has overflowed
    function automatic int acc_sum(input int n);
        if (m_acc == 0 || m_acc + n >= (1 << TDC_W)) return 0;
        return m_acc + n;
    endfunction

    // reference model that takes one sample word through the measurement rules
    function automatic void model_word(input logic [SAMPLE_W-1:0] w);
        int   n;
        logic short_p;
        logic start_w;
        n       = count_ones(w);
        short_p = (n > 0) && !w[0];
        start_w = (n > 0) && w[0];
        case (m_state)
            M_COUNT: begin
                if (w != 16'hFFFF || !m_en) begin
                    model_finish(acc_sum(n));
                    m_state = M_IDLE;
                end else begin
                    m_acc = acc_sum(n);
                end
            end
            M_ARMED: begin
                if (m_en && short_p) model_finish(n);
                if (start_w) begin
                    m_acc   = n;
                    m_state = M_COUNT;
                end else if (!m_en) begin
                    m_state = M_IDLE;
                end
            end
            default: begin
                if (m_en && short_p) model_finish(n);
                if (m_en && !m_arm && start_w) begin
                    m_acc   = n;
                    m_state = M_COUNT;
                end
            end
        endcase
    endfunction

    // hit follows the sample word by one cycle
    always @(posedge CLK40) hit_ref <= |sample_in;

    always @(negedge CLK40) begin
        if (hit_check_en) check_value("hit", 32'(hit), 32'(hit_ref));
    end

    // compare process pops the word at fifo_data on this edge
    always @(posedge CLK40) begin
        if (fifo_read && !fifo_empty) begin
            popped++;
            if (exp_q.size() == 0) begin
                $display("unexpected word 0x%08h read from the FIFO at %0t ns", fifo_data, $time);
                errors++;
            end else begin
                check_value("fifo_data", fifo_data, exp_q.pop_front());
            end
        end
        fifo_read <= drain_en;
    end

    task automatic send_word(input logic [SAMPLE_W-1:0] w);
        @(posedge CLK40);
        sample_in <= w;
        model_word(w);
    endtask

    // start phase s newest samples high, end phase e newest samples low
    task automatic send_pulse(input int s, input int n_full, input int e);
        send_word(16'((32'd1 << s) - 32'd1));
        repeat (n_full) send_word(16'hFFFF);
        send_word(16'(~((32'd1 << e) - 32'd1)));
        repeat (3) send_word('0);
    endtask

    task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input logic [7:0] data);
        @(posedge CLK40);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge CLK40);
        bus_wr      <= 1'b0;
        if (addr == ADDR_CTRL) begin
            model_reset();                  // soft reset clears the channel
        end else if (addr == ADDR_CONF) begin
            m_en  = data[CONF_EN_BIT];
            m_arm = data[CONF_ARM_BIT];
        end
    endtask

    task automatic check_reg(input logic [BUS_ADDR_W-1:0] addr, input logic [7:0] exp,
                             input string name);
        @(posedge CLK40);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge CLK40);
        bus_rd  <= 1'b0;
        @(negedge CLK40);                   // read data registered after bus_rd
        check_value(name, 32'(bus_data_out), 32'(exp));
    endtask

    task automatic pulse_arm();
        @(posedge CLK40);
        arm_tdc <= 1'b1;
        repeat (4) @(posedge CLK40);
        arm_tdc <= 1'b0;
        repeat (2) @(posedge CLK40);
        if (m_state == M_IDLE && m_en && m_arm) m_state = M_ARMED;
    endtask

    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        @(negedge CLK40);
        while ((exp_q.size() != 0 || !fifo_empty) && cycles < limit) begin
            @(negedge CLK40);
            cycles++;
        end
        if (exp_q.size() != 0 || !fifo_empty) begin
            $display("timeout at %0t ns: FIFO did not drain, %0d words still expected",
                     $time, exp_q.size());
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
    endtask

    initial begin
        int err0;
        int cycles;
        int a;
        int len;
        int pop0;
        sample_in   = '0;
        arm_tdc     = 1'b0;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        void'($urandom(1));
        model_reset();
        cycles = 0;
        while ((RST !== 1'b0) && cycles < 20) begin
            @(posedge CLK40);
            cycles++;
        end
        if (RST !== 1'b0) begin
            $display("reset was never released");
            errors++;
        end
        repeat (2) @(posedge CLK40);
        hit_check_en = 1'b1;

        err0 = errors;
        check_value("fifo_empty", 32'(fifo_empty), 32'd1);
        for (int i = 0; i <= 4; i++) check_reg(16'(i), 8'h00, "bus_data_out");
        bus_write(ADDR_CONF, 8'hA4);
        check_reg(ADDR_CONF, 8'hA4, "conf");
        check_reg(16'h0055, 8'h00, "bus_data_out unmapped");
        bus_write(ADDR_CTRL, 8'h3C);
        check_reg(ADDR_CTRL, 8'h3C, "scratch");
        check_reg(ADDR_CONF, 8'h00, "conf after soft reset");
        bus_write(ADDR_CTRL, 8'h00);
        check_reg(ADDR_CTRL, 8'h00, "scratch after soft reset");
        end_test("registers", err0);

        err0 = errors;
        bus_write(ADDR_CONF, 8'h01);
        for (int i = 0; i < 40; i++) begin
            send_pulse($urandom_range(16, 1), $urandom_range(198, 0), $urandom_range(16, 1));
        end
        wait_drained(100);
        check_reg(ADDR_EVT_LO, m_evt[7:0], "event_cnt low");
        end_test("long pulses", err0);

        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            a   = $urandom_range(15, 1);
            len = $urandom_range(16 - a, 1);
            send_word(16'(((32'd1 << len) - 32'd1) << a));
            send_word('0);
        end
        bus_write(ADDR_CONF, 8'h03);        // enable plus arm mode
        send_pulse(5, 10, 7);               // not armed so only the end word counts
        pulse_arm();
        send_pulse(9, 20, 3);
        send_pulse(2, 6, 12);               // armed state used up
        bus_write(ADDR_CONF, 8'h01);
        wait_drained(100);
        end_test("short pulses and arm", err0);

        err0 = errors;
        send_pulse(16, 300, 8);
        send_pulse(1, 255, 2);              // 4095 is the largest value
        send_pulse(1, 255, 1);              // reaches 4096
        wait_drained(100);
        check_reg(ADDR_EVT_LO, m_evt[7:0], "event_cnt low");
        end_test("overflow", err0);

        err0 = errors;
        drain_en = 1'b0;
        repeat (2) @(posedge CLK40);
        for (int i = 0; i < FIFO_DEPTH + 300; i++) send_word(16'h0FF0);
        repeat (4) send_word('0);
        check_reg(ADDR_LOST, 8'(m_lost), "lost_cnt");
        check_reg(ADDR_EVT_LO, m_evt[7:0], "event_cnt low");
        check_reg(ADDR_EVT_HI, m_evt[15:8], "event_cnt high");
        pop0     = popped;
        drain_en = 1'b1;
        wait_drained(FIFO_DEPTH + 50);
        check_value("words drained", 32'(popped - pop0), 32'(FIFO_DEPTH));
        end_test("fifo full", err0);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tdc_core.f
common/tdc_pkg.sv
common/bus_pkg.sv
verilog/word_fifo.sv
tdc/tdc_reg_bank.sv
tdc/tdc_measure.sv
verilog/tdc_core.sv
bench/clock_gen.sv
bench/tb_tdc_core.sv

//--- run_sim.sh
#!/bin/sh
# Builds the TDC channel testbench with Verilator and runs it.
# Pass or fail is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_tdc_core \
    -f tdc_core.f -Mdir "$BUILD_DIR" -o sim_tdc_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tdc_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed!" "$LOG"; then
    exit 0
fi
echo "simulation reported failures, see $LOG"
exit 1
